/* design/periph_pkg.sv */
package periph_pkg;

  // --------------------
  // Bus geometry
  // --------------------
  localparam int WB_DATA_WIDTH   = 32;
  localparam int WB_SEL_WIDTH    = WB_DATA_WIDTH / 8;
  localparam int WB_ADDR_WIDTH   = 32 - $clog2(WB_SEL_WIDTH);
  localparam int SLOT_WIDTH      = 4;
  localparam int WB_OFFSET_WIDTH = WB_ADDR_WIDTH - SLOT_WIDTH;

  typedef logic [WB_ADDR_WIDTH-1:0]   wb_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0]   wb_data_t;
  typedef logic [WB_SEL_WIDTH-1:0]    wb_sel_t;
  typedef logic [SLOT_WIDTH-1:0]      wb_slot_t;
  typedef logic [WB_OFFSET_WIDTH-1:0] wb_offset_t;

  // Slot map, top address bits
  localparam wb_slot_t SLOT_PWM   = 4'd2;
  localparam wb_slot_t SLOT_AUDIO = 4'd6;

  // --------------------
  // PWM driver
  // --------------------
  localparam int NUM_LEDS   = 4;
  localparam int PWM_PERIOD = 255;

  typedef logic [7:0] duty_t;

  // Word offsets inside the PWM slot
  localparam wb_offset_t REG_CTRL  = '0;
  localparam wb_offset_t REG_DUTY0 = wb_offset_t'(1);

  // --------------------
  // Audio level meter
  // --------------------
  localparam int LEVEL_WINDOW     = 12_000_000 / 200;
  localparam int WINDOW_CNT_WIDTH = $clog2(LEVEL_WINDOW);

  typedef logic signed [11:0]          sample_t;
  typedef logic [11:0]                 magnitude_t;
  typedef logic [3:0]                  level_t;
  typedef logic [WINDOW_CNT_WIDTH-1:0] window_cnt_t;

  // Wishbone classic request and response
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
    wb_sel_t  sel;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

endpackage

/* design/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder import periph_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,

  // Master side
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,

  // PWM driver slot
  output wb_req_t pwm_req_o,
  input  wb_rsp_t pwm_rsp_i,

  // Audio level meter slot
  output wb_req_t audio_req_o,
  input  wb_rsp_t audio_rsp_i
);

  wb_slot_t slot;
  logic     hit_pwm;
  logic     hit_audio;
  logic     hit_none;
  logic     dflt_ack_q;

  // --------------------
  // Slot decode
  // --------------------
  assign slot      = req_i.adr[WB_ADDR_WIDTH-1 -: SLOT_WIDTH];
  assign hit_pwm   = (slot == SLOT_PWM);
  assign hit_audio = (slot == SLOT_AUDIO);
  assign hit_none  = !hit_pwm && !hit_audio;

  // Request steering
  // Everything but stb fans out unchanged
  always_comb begin
    pwm_req_o       = req_i;
    pwm_req_o.stb   = req_i.stb && hit_pwm;

    audio_req_o     = req_i;
    audio_req_o.stb = req_i.stb && hit_audio;
  end

  // --------------------
  // Empty slots
  // --------------------
  // One-cycle ack, never back to back
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dflt_ack_q <= 1'b0;
    end else begin
      dflt_ack_q <= req_i.cyc && req_i.stb && hit_none && !dflt_ack_q;
    end
  end

  // --------------------
  // Response mux
  // --------------------
  always_comb begin
    rsp_o.ack = pwm_rsp_i.ack || audio_rsp_i.ack || dflt_ack_q;

    // Data follows whichever slave acks, empty slots read zero
    if (pwm_rsp_i.ack) begin
      rsp_o.dat = pwm_rsp_i.dat;
    end else if (audio_rsp_i.ack) begin
      rsp_o.dat = audio_rsp_i.dat;
    end else begin
      rsp_o.dat = '0;
    end
  end

endmodule

/* design/pwm_controller.sv */
`timescale 1ns/1ps

module pwm_controller import periph_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n_i,

  // Wishbone slave
  input  wb_req_t              req_i,
  output wb_rsp_t              rsp_o,

  // Shared time base for the channels
  output duty_t                count_o,
  output logic                 period_start_o,
  output logic                 enable_o,

  // Per-channel duty
  output duty_t [NUM_LEDS-1:0] duty_o
);

  wb_offset_t            offset;
  logic                  access;
  logic                  wr_byte0;
  logic                  ack_q;
  wb_data_t              rd_data;
  wb_data_t              rd_data_q;

  logic                  enable_q;
  duty_t [NUM_LEDS-1:0]  duty_q;
  duty_t                 count_q;

  // --------------------
  // Bus handshake
  // --------------------
  assign offset   = req_i.adr[WB_OFFSET_WIDTH-1:0];
  assign access   = req_i.cyc && req_i.stb && !ack_q;
  assign wr_byte0 = access && req_i.we && req_i.sel[0];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Read mux, registers zero-extended
  always_comb begin
    rd_data = '0;
    if (offset == REG_CTRL) begin
      rd_data[0] = enable_q;
    end
    for (int i = 0; i < NUM_LEDS; i++) begin
      if (offset == wb_offset_t'(REG_DUTY0 + i)) begin
        rd_data[7:0] = duty_q[i];
      end
    end
  end

  // Read data is held for the ack cycle
  always_ff @(posedge clk) begin
    if (access) begin
      rd_data_q <= rd_data;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rd_data_q;

  // --------------------
  // Register file
  // --------------------
  // Writes land on the edge that raises ack
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      duty_q   <= '0;
    end else if (wr_byte0) begin
      if (offset == REG_CTRL) begin
        enable_q <= req_i.dat[0];
      end
      for (int i = 0; i < NUM_LEDS; i++) begin
        if (offset == wb_offset_t'(REG_DUTY0 + i)) begin
          duty_q[i] <= req_i.dat[7:0];
        end
      end
    end
  end

  assign enable_o = enable_q;
  assign duty_o   = duty_q;

  // --------------------
  // Period counter
  // --------------------
  // Runs 0 .. PWM_PERIOD-1
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (count_q == duty_t'(PWM_PERIOD - 1)) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o        = count_q;
  assign period_start_o = (count_q == '0);

endmodule

/* design/pwm_channel.sv */
`timescale 1ns/1ps

module pwm_channel import periph_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,

  input  duty_t count_i,
  input  logic  period_start_i,
  input  logic  enable_i,

  input  duty_t duty_i,
  output logic  led_o
);

  duty_t active_q;
  duty_t active_eff;
  logic  led_q;

  // New duty takes over at the start of a period only
  assign active_eff = period_start_i ? duty_i : active_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= '0;
    end else if (period_start_i) begin
      active_q <= duty_i;
    end
  end

  // Full-scale duty keeps the LED on across the whole period
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_q <= 1'b0;
    end else begin
      led_q <= enable_i &&
               ((active_eff == duty_t'(PWM_PERIOD)) || (count_i < active_eff));
    end
  end

  assign led_o = led_q;

endmodule

/* design/audio_level_meter.sv */
`timescale 1ns/1ps

module audio_level_meter import periph_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,

  // Wishbone slave
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,

  // Sample stream
  input  sample_t sample_i,
  input  logic    sample_valid_i
);

  // Highest set bit of the peak picks the level
  function automatic level_t peak_to_level(magnitude_t peak);
    level_t lvl;
    if (peak[11] || peak[10])  lvl = 4'd10;
    else if (peak[9])          lvl = 4'd8;
    else if (peak[8])          lvl = 4'd6;
    else if (peak[7])          lvl = 4'd4;
    else if (peak[6])          lvl = 4'd3;
    else if (peak[5])          lvl = 4'd2;
    else if (peak[4])          lvl = 4'd1;
    else                       lvl = 4'd0;
    return lvl;
  endfunction

  magnitude_t  magnitude;
  magnitude_t  peak_q;
  magnitude_t  peak_cur;
  window_cnt_t window_q;
  logic        window_end;
  level_t      level_q;

  logic        access;
  logic        ack_q;
  wb_data_t    rd_data_q;

  // --------------------
  // Peak tracking
  // --------------------
  // -2048 negates to 12'h800, read as 2048 unsigned
  assign magnitude  = sample_i[11] ? magnitude_t'(-sample_i) : magnitude_t'(sample_i);
  assign peak_cur   = (sample_valid_i && (magnitude > peak_q)) ? magnitude : peak_q;
  assign window_end = (window_q == window_cnt_t'(LEVEL_WINDOW - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      window_q <= '0;
      peak_q   <= '0;
      level_q  <= '0;
    end else if (window_end) begin
      window_q <= '0;
      peak_q   <= '0;
      level_q  <= peak_to_level(peak_cur);
    end else begin
      window_q <= window_q + 1'b1;
      peak_q   <= peak_cur;
    end
  end

  // --------------------
  // Bus access
  // --------------------
  // Level at offset 0, writes acked and dropped
  assign access = req_i.cyc && req_i.stb && !ack_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rd_data_q <= (req_i.adr[WB_OFFSET_WIDTH-1:0] == '0) ? wb_data_t'(level_q) : '0;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rd_data_q;

endmodule

/* design/periph_top.sv */
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
  input  logic                clk,
  input  logic                rst_n_i,

  // Wishbone slave port
  input  wb_req_t             wb_req_i,
  output wb_rsp_t             wb_rsp_o,

  // Audio samples
  input  sample_t             sample_i,
  input  logic                sample_valid_i,

  // Status LEDs
  output logic [NUM_LEDS-1:0] led_o
);

  wb_req_t              pwm_req;
  wb_rsp_t              pwm_rsp;
  wb_req_t              audio_req;
  wb_rsp_t              audio_rsp;

  duty_t                pwm_count;
  logic                 pwm_period_start;
  logic                 pwm_enable;
  duty_t [NUM_LEDS-1:0] pwm_duty;

  // --------------------
  // Address decode
  // --------------------
  wb_decoder wb_decoder_inst (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .req_i       ( wb_req_i  ),
    .rsp_o       ( wb_rsp_o  ),
    .pwm_req_o   ( pwm_req   ),
    .pwm_rsp_i   ( pwm_rsp   ),
    .audio_req_o ( audio_req ),
    .audio_rsp_i ( audio_rsp )
  );

  // --------------------
  // PWM LED driver
  // --------------------
  pwm_controller pwm_controller_inst (
    .clk            ( clk              ),
    .rst_n_i        ( rst_n_i          ),
    .req_i          ( pwm_req          ),
    .rsp_o          ( pwm_rsp          ),
    .count_o        ( pwm_count        ),
    .period_start_o ( pwm_period_start ),
    .enable_o       ( pwm_enable       ),
    .duty_o         ( pwm_duty         )
  );

  for (genvar i = 0; i < NUM_LEDS; i++) begin : g_pwm_ch
    pwm_channel pwm_channel_inst (
      .clk            ( clk              ),
      .rst_n_i        ( rst_n_i          ),
      .count_i        ( pwm_count        ),
      .period_start_i ( pwm_period_start ),
      .enable_i       ( pwm_enable       ),
      .duty_i         ( pwm_duty[i]      ),
      .led_o          ( led_o[i]         )
    );
  end

  // Level meter
  audio_level_meter audio_level_meter_inst (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( audio_req      ),
    .rsp_o          ( audio_rsp      ),
    .sample_i       ( sample_i       ),
    .sample_valid_i ( sample_valid_i )
  );

endmodule

/* sim/tb_periph_top.sv */
`timescale 1ns/1ps

module tb_periph_top import periph_pkg::*; ();

  localparam int       BUS_TIMEOUT  = 16;
  localparam int       PHASE_CYCLES = 2 * LEVEL_WINDOW + 100;
  localparam int       PEAK_SPACING = 1000;
  localparam wb_slot_t SLOT_EMPTY   = 4'd5;

  logic                clk;
  logic                rst_n_i;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  sample_t             sample;
  logic                sample_valid;
  logic [NUM_LEDS-1:0] led;

  logic [31:0]         lfsr_state;
  logic                exp_enable;
  duty_t               exp_duty [NUM_LEDS];

  periph_top periph_top_inst (
    .clk            ( clk          ),
    .rst_n_i        ( rst_n_i      ),
    .wb_req_i       ( wb_req       ),
    .wb_rsp_o       ( wb_rsp       ),
    .sample_i       ( sample       ),
    .sample_valid_i ( sample_valid ),
    .led_o          ( led          )
  );

  always #2 clk = ~clk;

  // --------------------
  // Checking helpers
  // --------------------
  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // Level from the peak magnitude thresholds
  function automatic int level_for_peak(input int peak);
    if (peak >= 1024) return 10;
    else if (peak >= 512) return 8;
    else if (peak >= 256) return 6;
    else if (peak >= 128) return 4;
    else if (peak >= 64) return 3;
    else if (peak >= 32) return 2;
    else if (peak >= 16) return 1;
    else return 0;
  endfunction

  // --------------------
  // Bus master
  // --------------------
  task automatic bus_cycle(input logic we, input wb_slot_t slot, input wb_offset_t offset,
                           input wb_data_t wdata, input wb_sel_t sel,
                           output wb_data_t rdata);
    int waited;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = {slot, offset};
    wb_req.dat = wdata;
    wb_req.sel = sel;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
    assert (wb_rsp.ack) else begin
      $display("No ack from slot %0d offset %0d within %0d cycles", slot, offset, waited);
      stop_on_failure();
    end
    check_value("ack latency", 1, waited);
    rdata  = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic bus_write(input wb_slot_t slot, input wb_offset_t offset,
                           input wb_data_t wdata, input wb_sel_t sel);
    wb_data_t unused;
    bus_cycle(1'b1, slot, offset, wdata, sel, unused);
  endtask

  task automatic bus_read(input wb_slot_t slot, input wb_offset_t offset,
                          output wb_data_t rdata);
    bus_cycle(1'b0, slot, offset, '0, '1, rdata);
  endtask

  task automatic check_pwm_regs();
    wb_data_t rdata;
    bus_read(SLOT_PWM, REG_CTRL, rdata);
    check_value("ctrl", exp_enable, rdata);
    for (int i = 0; i < NUM_LEDS; i++) begin
      bus_read(SLOT_PWM, wb_offset_t'(REG_DUTY0 + i), rdata);
      check_value($sformatf("duty%0d", i), exp_duty[i], rdata);
    end
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic reset_state();
    wb_data_t rdata;
    repeat (2 * PWM_PERIOD) begin
      @(negedge clk);
      check_value("led_o", 0, led);
    end
    check_pwm_regs();
    bus_read(SLOT_AUDIO, '0, rdata);
    check_value("level", 0, rdata);
  endtask

  task automatic register_access();
    wb_data_t rdata;
    for (int i = 0; i < NUM_LEDS; i++) begin
      exp_duty[i] = duty_t'(random_bits(8));
      bus_write(SLOT_PWM, wb_offset_t'(REG_DUTY0 + i), {24'h0, exp_duty[i]}, 4'b0001);
    end
    exp_enable = 1'b1;
    bus_write(SLOT_PWM, REG_CTRL, 32'h1, 4'b0001);
    check_pwm_regs();
    // Writes without byte 0 must change nothing
    bus_write(SLOT_PWM, REG_CTRL, 32'h0, 4'b1110);
    bus_write(SLOT_PWM, REG_DUTY0, ~{24'h0, exp_duty[0]}, 4'b1110);
    bus_write(SLOT_PWM, wb_offset_t'(REG_DUTY0 + NUM_LEDS), '1, '1);
    check_pwm_regs();
    bus_read(SLOT_PWM, wb_offset_t'(REG_DUTY0 + NUM_LEDS), rdata);
    check_value("unknown offset", 0, rdata);
  endtask

  task automatic pwm_duty();
    int high_cnt [NUM_LEDS];
    int waited;
    exp_duty[0] = 8'd0;
    exp_duty[1] = 8'd255;
    exp_duty[2] = duty_t'(random_bits(8));
    exp_duty[3] = duty_t'(random_bits(8));
    for (int i = 0; i < NUM_LEDS; i++) begin
      bus_write(SLOT_PWM, wb_offset_t'(REG_DUTY0 + i), {24'h0, exp_duty[i]}, 4'b0001);
    end
    exp_enable = 1'b1;
    bus_write(SLOT_PWM, REG_CTRL, 32'h1, 4'b0001);
    // Let the new duties reach a period start
    repeat (PWM_PERIOD + 1) @(negedge clk);
    for (int i = 0; i < NUM_LEDS; i++) high_cnt[i] = 0;
    repeat (4 * PWM_PERIOD) begin
      @(negedge clk);
      for (int i = 0; i < NUM_LEDS; i++) high_cnt[i] += led[i];
    end
    for (int i = 0; i < NUM_LEDS; i++) begin
      check_value($sformatf("led_o[%0d] high cycles", i), 4 * exp_duty[i], high_cnt[i]);
    end
    exp_enable = 1'b0;
    bus_write(SLOT_PWM, REG_CTRL, 32'h0, 4'b0001);
    waited = 0;
    while (led != '0 && waited < PWM_PERIOD) begin
      @(negedge clk);
      waited++;
    end
    check_value("led_o after disable", 0, led);
  endtask

  task automatic empty_slot();
    wb_data_t rdata;
    bus_read(SLOT_EMPTY, '0, rdata);
    check_value("empty slot data", 0, rdata);
    bus_write(SLOT_EMPTY, REG_CTRL, '1, '1);
    bus_write(SLOT_EMPTY, REG_DUTY0, '1, '1);
    check_pwm_regs();
    bus_read(SLOT_AUDIO, '0, rdata);
    check_value("level", 0, rdata);
  endtask

  // Each phase repeats its peak often enough to land in every window
  task automatic audio_level();
    wb_data_t rdata;
    int       peak_mag;
    int       width;
    int       mag;
    logic     neg;
    for (int phase = 0; phase < 3; phase++) begin
      width    = 4 + random_bits(3);
      peak_mag = (phase == 2) ? 2048 : (random_bits(width) | (1 << (width - 1)));
      for (int n = 0; n < PHASE_CYCLES; n++) begin
        @(negedge clk);
        mag = (n % PEAK_SPACING == 0) ? peak_mag : random_bits(12) % (peak_mag + 1);
        neg = lfsr_step() || (mag == 2048);
        sample       = neg ? sample_t'(-mag) : sample_t'(mag);
        sample_valid = 1'b1;
      end
      @(negedge clk);
      sample       = '0;
      sample_valid = 1'b0;
      bus_read(SLOT_AUDIO, '0, rdata);
      check_value($sformatf("level for peak %0d", peak_mag), level_for_peak(peak_mag), rdata);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    wb_req       = '0;
    sample       = '0;
    sample_valid = 1'b0;
    lfsr_state   = 32'hfd10_1fab;
    exp_enable   = 1'b0;
    for (int i = 0; i < NUM_LEDS; i++) exp_duty[i] = '0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    reset_state();
    register_access();
    pwm_duty();
    empty_slot();
    audio_level();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* flist.f */
design/periph_pkg.sv
design/wb_decoder.sv
design/pwm_controller.sv
design/pwm_channel.sv
design/audio_level_meter.sv
design/periph_top.sv
sim/tb_periph_top.sv

/* Bender.yml */
package:
  name: periph_top

sources:
  - files:
      - design/periph_pkg.sv
      - design/wb_decoder.sv
      - design/pwm_controller.sv
      - design/pwm_channel.sv
      - design/audio_level_meter.sv
      - design/periph_top.sv
  - target: simulation
    files:
      - sim/tb_periph_top.sv
